//--- tb.f
+incdir+hw
hw/int_res_pkg.sv
hw/int_res_bank.sv
hw/int_res_bank_map.sv
hw/int_res_write_pack.sv
hw/int_res_read_unpack.sv
hw/int_res_mem.sv
sim/int_res_mem_sva.sv
sim/int_res_mem_tb.sv

//--- sim/int_res_mem_tb.sv
`timescale 1ns/10ps
`include "int_res_macros.svh"

module int_res_mem_tb;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_WORDS   = `INT_RES_BANKS * `INT_RES_BANK_DEPTH;
    localparam int RAND_OPS    = 200;
    // Reset, pipeline, single, double, placement, fill and random phases
    localparam int TEST_CYCLES = 2 + 8 + 40 + 12 + 4 + NUM_WORDS + RAND_OPS;
    localparam int MARGIN      = 50;

    logic                         clk;
    logic                         rst_n;
    int_res_pkg::int_res_wr_req_t wr_req;
    int_res_pkg::int_res_rd_req_t rd_req;
    int_res_pkg::int_res_comp_t   rd_data;
    logic                         rd_valid;

    // Expected contents, indexed by flat address
    int_res_pkg::int_res_word_t model [NUM_WORDS];
    int error_count = 0;

    int_res_mem i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .rd_req   (rd_req),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("TESTBENCH FAILED");
        $fatal(1, "Watchdog expired");
    end

    function automatic int format_int_bits(input int_res_pkg::int_res_fmt_e fmt);
        case (fmt)
            int_res_pkg::fmt_sw_1: return 1;
            int_res_pkg::fmt_sw_2: return 2;
            int_res_pkg::fmt_sw_4: return 4;
            int_res_pkg::fmt_sw_6: return 6;
            default:               return 5;
        endcase
    endfunction

    // Keep sign, then 14 bits starting at compute bit 18+k
    function automatic logic [14:0] to_single(input logic [31:0] data, input int k);
        logic [31:0] shifted;
        shifted = data >> (5 + k);
        return {data[31], shifted[13:0]};
    endfunction

    function automatic logic [29:0] to_double(input logic [31:0] data);
        return {data[31], data[28:0]};
    endfunction

    // 15-k fraction bits widened to 20
    function automatic logic [31:0] from_single(input logic [14:0] w, input int k);
        logic [31:0] ext;
        ext = {{17{w[14]}}, w};
        return ext << (5 + k);
    endfunction

    function automatic logic [31:0] from_double(input logic [29:0] w);
        return {{2{w[29]}}, w};
    endfunction

    function automatic logic [31:0] predict_read(input int addr,
                                                 input int_res_pkg::int_res_width_e width,
                                                 input int_res_pkg::int_res_fmt_e fmt);
        int ofs;
        int pair;
        ofs  = addr % 16;
        pair = (addr / 16) % 2;
        if (width == int_res_pkg::double_width) begin
            return from_double({model[pair * 16 + ofs], model[(pair + 2) * 16 + ofs]});
        end
        return from_single(model[addr], format_int_bits(fmt));
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s = %h, expected %h", name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic write_word(input int addr, input int_res_pkg::int_res_width_e width,
                              input int_res_pkg::int_res_fmt_e fmt, input logic [31:0] data);
        int          ofs;
        int          pair;
        logic [29:0] dw;
        ofs  = addr % 16;
        pair = (addr / 16) % 2;
        dw   = to_double(data);
        if (width == int_res_pkg::double_width) begin
            model[pair * 16 + ofs]       = dw[29:15];
            model[(pair + 2) * 16 + ofs] = dw[14:0];
        end else begin
            model[addr] = to_single(data, format_int_bits(fmt));
        end
        wr_req = '{en: 1'b1, addr: addr[5:0], width: width, fmt: fmt, data: data};
        @(posedge clk);
        #1;
        wr_req.en = 1'b0;
        compare_value("rd_valid", {31'b0, rd_valid}, 32'h0);
    endtask

    task automatic read_check(input int addr, input int_res_pkg::int_res_width_e width,
                              input int_res_pkg::int_res_fmt_e fmt, input logic [31:0] expected);
        rd_req = '{en: 1'b1, addr: addr[5:0], width: width, fmt: fmt};
        @(posedge clk);
        #1;
        compare_value("rd_valid", {31'b0, rd_valid}, 32'h1);
        compare_value("rd_data", rd_data, expected);
        rd_req.en = 1'b0;
    endtask

    task automatic test_valid_timing();
        compare_value("rd_valid", {31'b0, rd_valid}, 32'h0);
        @(posedge clk);
        #1;
        compare_value("rd_valid", {31'b0, rd_valid}, 32'h0);
        write_word(10, int_res_pkg::single_width, int_res_pkg::fmt_sw_4, 32'h0012_3456);
        write_word(27, int_res_pkg::single_width, int_res_pkg::fmt_sw_4, 32'hfff8_9abc);
        // Two reads back to back, then one idle cycle
        rd_req = '{en: 1'b1, addr: 6'd10, width: int_res_pkg::single_width,
                   fmt: int_res_pkg::fmt_sw_4};
        @(posedge clk);
        #1;
        compare_value("rd_valid", {31'b0, rd_valid}, 32'h1);
        compare_value("rd_data", rd_data,
                      predict_read(10, int_res_pkg::single_width, int_res_pkg::fmt_sw_4));
        rd_req.addr = 6'd27;
        @(posedge clk);
        #1;
        compare_value("rd_valid", {31'b0, rd_valid}, 32'h1);
        compare_value("rd_data", rd_data,
                      predict_read(27, int_res_pkg::single_width, int_res_pkg::fmt_sw_4));
        rd_req.en = 1'b0;
        @(posedge clk);
        #1;
        compare_value("rd_valid", {31'b0, rd_valid}, 32'h0);
    endtask

    task automatic test_single_formats();
        int                        addr;
        int_res_pkg::int_res_fmt_e fmt;
        for (int bank = 0; bank < 4; bank++) begin
            for (int f = 0; f < 5; f++) begin
                fmt  = int_res_pkg::int_res_fmt_e'(f);
                addr = bank * 16 + $urandom_range(0, 15);
                write_word(addr, int_res_pkg::single_width, fmt, $urandom());
                read_check(addr, int_res_pkg::single_width, fmt,
                           predict_read(addr, int_res_pkg::single_width, fmt));
            end
        end
    endtask

    task automatic test_double_width();
        int          addrs [4] = '{3, 35, 20, 60};
        logic [31:0] data;
        logic [31:0] r;
        // Values that fit 10 integer and 20 fraction bits come back unchanged
        foreach (addrs[i]) begin
            r    = $urandom();
            data = {{3{r[31]}}, r[28:0]};
            write_word(addrs[i], int_res_pkg::double_width, int_res_pkg::fmt_dw, data);
            read_check(addrs[i], int_res_pkg::double_width, int_res_pkg::fmt_dw, data);
        end
        // Too large, so high bits are lost
        data = 32'h5123_4567;
        write_word(44, int_res_pkg::double_width, int_res_pkg::fmt_dw, data);
        read_check(44, int_res_pkg::double_width, int_res_pkg::fmt_dw,
                   predict_read(44, int_res_pkg::double_width, int_res_pkg::fmt_dw));
    endtask

    task automatic test_pair_placement();
        logic [31:0] data;
        logic [29:0] dw;
        data = 32'h0a5c_3e71;
        dw   = to_double(data);
        write_word(39, int_res_pkg::double_width, int_res_pkg::fmt_dw, data);
        read_check(7, int_res_pkg::single_width, int_res_pkg::fmt_sw_1,
                   from_single(dw[29:15], 1));
        read_check(39, int_res_pkg::single_width, int_res_pkg::fmt_sw_1,
                   from_single(dw[14:0], 1));
    endtask

    task automatic test_random_traffic();
        int                          addr;
        int_res_pkg::int_res_width_e width;
        int_res_pkg::int_res_fmt_e   fmt;
        // Every location defined before random reads
        for (int a = 0; a < NUM_WORDS; a++) begin
            write_word(a, int_res_pkg::single_width, int_res_pkg::fmt_sw_5, $urandom());
        end
        for (int n = 0; n < RAND_OPS; n++) begin
            addr  = $urandom_range(0, NUM_WORDS - 1);
            width = int_res_pkg::int_res_width_e'($urandom_range(0, 1));
            if (width == int_res_pkg::double_width) begin
                fmt = int_res_pkg::fmt_dw;
            end else begin
                fmt = int_res_pkg::int_res_fmt_e'($urandom_range(0, 4));
            end
            if ($urandom_range(0, 1) == 1) begin
                write_word(addr, width, fmt, $urandom());
            end else begin
                read_check(addr, width, fmt, predict_read(addr, width, fmt));
            end
        end
    endtask

    initial begin
        void'($urandom(32'h21c4f9bc));
        rst_n  = 1'b0;
        wr_req = '0;
        // A read held during reset must not show up as rd_valid
        rd_req = '{en: 1'b1, addr: 6'd0, width: int_res_pkg::single_width,
                   fmt: int_res_pkg::fmt_sw_1};
        repeat (2) @(posedge clk);
        #1;
        rst_n     = 1'b1;
        rd_req.en = 1'b0;

        test_valid_timing();
        test_single_formats();
        test_double_width();
        test_pair_placement();
        test_random_traffic();

        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- sim/int_res_mem_sva.sv
`timescale 1ns/10ps
`include "int_res_macros.svh"

module int_res_mem_sva (
    input logic                           clk,
    input logic                           rst_n,
    input int_res_pkg::int_res_wr_req_t   wr_req,
    input int_res_pkg::int_res_rd_req_t   rd_req,
    input int_res_pkg::int_res_bank_sel_t wr_sel,
    input int_res_pkg::int_res_bank_sel_t rd_sel
);

    // Double width only with the double-width format
    a_wr_dw_fmt: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_req.en && wr_req.width == int_res_pkg::double_width)
        |-> wr_req.fmt == int_res_pkg::fmt_dw)
        else $error("Double-width write without fmt_dw");

    a_rd_dw_fmt: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_req.en && rd_req.width == int_res_pkg::double_width)
        |-> rd_req.fmt == int_res_pkg::fmt_dw)
        else $error("Double-width read without fmt_dw");

    // A write would steal the port from the read
    a_no_collision: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_sel.en_mask & rd_sel.en_mask) == '0)
        else $error("Read and write share a bank");

endmodule

bind int_res_mem int_res_mem_sva i_sva (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .wr_sel (wr_sel),
    .rd_sel (rd_sel)
);

//--- hw/int_res_mem.sv
`timescale 1ns/10ps
`include "int_res_macros.svh"

module int_res_mem (
    input  logic                         clk,
    input  logic                         rst_n,
    input  int_res_pkg::int_res_wr_req_t wr_req,
    input  int_res_pkg::int_res_rd_req_t rd_req,
    output int_res_pkg::int_res_comp_t   rd_data,
    output logic                         rd_valid
);

    int_res_pkg::int_res_bank_sel_t wr_sel;
    int_res_pkg::int_res_bank_sel_t rd_sel;

    int_res_pkg::int_res_word_t bank_wdata [`INT_RES_BANKS];
    int_res_pkg::int_res_word_t bank_rword [`INT_RES_BANKS];

    int_res_bank_map u_wr_map (
        .addr  (wr_req.addr),
        .en    (wr_req.en),
        .width (wr_req.width),
        .sel   (wr_sel)
    );

    int_res_bank_map u_rd_map (
        .addr  (rd_req.addr),
        .en    (rd_req.en),
        .width (rd_req.width),
        .sel   (rd_sel)
    );

    int_res_write_pack u_write_pack (
        .req        (wr_req),
        .sel        (wr_sel),
        .bank_wdata (bank_wdata)
    );

    int_res_read_unpack u_read_unpack (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (rd_req),
        .sel        (rd_sel),
        .bank_rword (bank_rword),
        .data       (rd_data),
        .valid      (rd_valid)
    );

    // Both sides share one offset per side across all banks
    for (genvar b = 0; b < `INT_RES_BANKS; b++) begin : g_bank
        int_res_bank u_bank (
            .clk     (clk),
            .rd_en   (rd_sel.en_mask[b]),
            .rd_ofs  (rd_sel.ofs),
            .wr_en   (wr_sel.en_mask[b]),
            .wr_ofs  (wr_sel.ofs),
            .wr_data (bank_wdata[b]),
            .rd_word (bank_rword[b])
        );
    end

endmodule

//--- hw/int_res_read_unpack.sv
`timescale 1ns/10ps
`include "int_res_macros.svh"

module int_res_read_unpack (
    input  logic                           clk,
    input  logic                           rst_n,
    input  int_res_pkg::int_res_rd_req_t   req,
    input  int_res_pkg::int_res_bank_sel_t sel,
    input  int_res_pkg::int_res_word_t     bank_rword [`INT_RES_BANKS],
    output int_res_pkg::int_res_comp_t     data,
    output logic                           valid
);

    localparam int W = `INT_RES_WORD_W;

    logic                                      en_q;
    logic [`INT_RES_ADDR_W-`INT_RES_OFS_W-1:0] idx_q;
    int_res_pkg::int_res_width_e               width_q;
    int_res_pkg::int_res_fmt_e                 fmt_q;

    int_res_pkg::int_res_word_t msh_word;
    int_res_pkg::int_res_word_t lsh_word;
    int_res_pkg::int_res_word_t sw_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_q <= 1'b0;
        end else begin
            en_q <= req.en;
        end
    end

    // Selection of the request in flight
    always_ff @(posedge clk) begin
        if (req.en) begin
            idx_q   <= sel.idx;
            width_q <= req.width;
            fmt_q   <= req.fmt;
        end
    end

    assign valid = en_q;

    // Pair banks are {half, parity}
    assign msh_word = bank_rword[{int_res_pkg::msh, idx_q[0]}];
    assign lsh_word = bank_rword[{int_res_pkg::lsh, idx_q[0]}];
    assign sw_word  = bank_rword[idx_q];

    always_comb begin
        int k;
        k = int_res_pkg::fmt_int_bits(fmt_q);
        if (width_q == int_res_pkg::double_width) begin
            data = int_res_pkg::int_res_comp_t'($signed({msh_word, lsh_word}))
                   << (`INT_RES_COMP_FRAC - `INT_RES_DW_FRAC);
        end else begin
            // Stored word carries W-k fraction bits
            data = int_res_pkg::int_res_comp_t'($signed(sw_word))
                   << (`INT_RES_COMP_FRAC - (W - k));
        end
    end

endmodule

//--- hw/int_res_write_pack.sv
`timescale 1ns/10ps
`include "int_res_macros.svh"

module int_res_write_pack (
    input  int_res_pkg::int_res_wr_req_t   req,
    input  int_res_pkg::int_res_bank_sel_t sel,
    output int_res_pkg::int_res_word_t     bank_wdata [`INT_RES_BANKS]
);

    localparam int W    = `INT_RES_WORD_W;
    localparam int DW_W = 2 * `INT_RES_WORD_W;

    // Top bit of the double-width magnitude field in compute format
    localparam int DW_TOP = `INT_RES_COMP_FRAC + (DW_W - `INT_RES_DW_FRAC) - 2;

    logic [DW_W-1:0]            dw_word;
    int_res_pkg::int_res_word_t sw_word;

    function automatic int_res_pkg::int_res_word_t dw_half(
        input logic [DW_W-1:0]         dw,
        input int_res_pkg::int_res_half_e half
    );
        if (half == int_res_pkg::msh) begin
            return dw[DW_W-1 -: W];
        end
        return dw[W-1:0];
    endfunction

    // Truncate low bits, drop high bits, keep the sign
    always_comb begin
        int k;
        k = int_res_pkg::fmt_int_bits(req.fmt);
        sw_word = {req.data[`INT_RES_COMP_W-1], req.data[`INT_RES_COMP_FRAC + k - 2 -: W-1]};
        dw_word = {req.data[`INT_RES_COMP_W-1], req.data[DW_TOP -: DW_W-1]};
    end

    always_comb begin
        int_res_pkg::int_res_half_e half;
        for (int b = 0; b < `INT_RES_BANKS; b++) begin
            // Lower bank numbers hold the MSH
            half = (b < `INT_RES_BANKS / 2) ? int_res_pkg::msh : int_res_pkg::lsh;
            if (!sel.en_mask[b]) begin
                bank_wdata[b] = '0;
            end else if (req.width == int_res_pkg::double_width) begin
                bank_wdata[b] = dw_half(dw_word, half);
            end else begin
                bank_wdata[b] = sw_word;
            end
        end
    end

endmodule

//--- hw/int_res_bank_map.sv
`timescale 1ns/10ps
`include "int_res_macros.svh"

module int_res_bank_map (
    input  logic [`INT_RES_ADDR_W-1:0]      addr,
    input  logic                            en,
    input  int_res_pkg::int_res_width_e     width,
    output int_res_pkg::int_res_bank_sel_t  sel
);

    always_comb begin
        sel = '0;

        // Upper address bits pick the bank
        sel.idx = addr[`INT_RES_ADDR_W-1:`INT_RES_OFS_W];
        sel.ofs = addr[`INT_RES_OFS_W-1:0];

        // Double width pairs 0/2 or 1/3, picked by bank parity
        for (int b = 0; b < `INT_RES_BANKS; b++) begin
            if (width == int_res_pkg::double_width) begin
                sel.en_mask[b] = en && ((b % 2) == int'(sel.idx[0]));
            end else begin
                sel.en_mask[b] = en && (b == int'(sel.idx));
            end
        end
    end

endmodule

//--- hw/int_res_bank.sv
`timescale 1ns/10ps
`include "int_res_macros.svh"

module int_res_bank (
    input  logic                       clk,
    input  logic                       rd_en,
    input  logic [`INT_RES_OFS_W-1:0]  rd_ofs,
    input  logic                       wr_en,
    input  logic [`INT_RES_OFS_W-1:0]  wr_ofs,
    input  int_res_pkg::int_res_word_t wr_data,
    output int_res_pkg::int_res_word_t rd_word
);

    int_res_pkg::int_res_word_t mem [`INT_RES_BANK_DEPTH];

    // Single port, a write owns the port for the cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ofs] <= wr_data;
        end else if (rd_en) begin
            rd_word <= mem[rd_ofs];
        end
    end

endmodule

//--- hw/int_res_pkg.sv
`include "int_res_macros.svh"

package int_res_pkg;

    typedef logic [`INT_RES_WORD_W-1:0] int_res_word_t;
    typedef logic [`INT_RES_COMP_W-1:0] int_res_comp_t;

    typedef enum logic {
        single_width,
        double_width
    } int_res_width_e;

    // Number in the name is integer bits, sign included
    typedef enum logic [2:0] {
        fmt_sw_1,
        fmt_sw_2,
        fmt_sw_4,
        fmt_sw_5,
        fmt_sw_6,
        fmt_dw
    } int_res_fmt_e;

    typedef enum logic {
        msh,
        lsh
    } int_res_half_e;

    typedef struct packed {
        logic                       en;
        logic [`INT_RES_ADDR_W-1:0] addr;
        int_res_width_e             width;
        int_res_fmt_e               fmt;
    } int_res_rd_req_t;

    typedef struct packed {
        logic                       en;
        logic [`INT_RES_ADDR_W-1:0] addr;
        int_res_width_e             width;
        int_res_fmt_e               fmt;
        int_res_comp_t              data;
    } int_res_wr_req_t;

    typedef struct packed {
        logic [`INT_RES_BANKS-1:0]                  en_mask;
        logic [`INT_RES_ADDR_W-`INT_RES_OFS_W-1:0] idx;
        logic [`INT_RES_OFS_W-1:0]                  ofs;
    } int_res_bank_sel_t;

    // Integer bits of a single-width format; unlisted codes behave as 5
    function automatic int fmt_int_bits(input int_res_fmt_e fmt);
        case (fmt)
            fmt_sw_1: return 1;
            fmt_sw_2: return 2;
            fmt_sw_4: return 4;
            fmt_sw_6: return 6;
            default:  return 5;
        endcase
    endfunction

endpackage

//--- hw/int_res_macros.svh
`ifndef INT_RES_MACROS_SVH
`define INT_RES_MACROS_SVH

// Storage word and double-width format
`define INT_RES_WORD_W 15
`define INT_RES_DW_FRAC 20

// Compute datapath format
`define INT_RES_COMP_W 32
`define INT_RES_COMP_FRAC 20

// Bank organisation
`define INT_RES_BANK_DEPTH 16
`define INT_RES_BANKS 4
`define INT_RES_ADDR_W 6
`define INT_RES_OFS_W 4

`endif
